// ==== verilog/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    localparam int index_width = 4;
    localparam int way_count   = 2;
    localparam int tag_width   = 26;
    localparam int op_ibar_bit = 31;

    // cache-op codes, code 0 falls back to index-invalidate
    localparam logic [1:0] cacop_index_inv = 2'd1;
    localparam logic [1:0] cacop_hit_inv   = 2'd2;

    typedef struct packed {
        logic [tag_width-1:0]   tag;
        logic [index_width-1:0] index;
        logic [1:0]             offset;   // word offset, only bit 0 is looked at
    } icache_addr_t;

    typedef struct packed {
        logic                   ibar;
        logic [op_ibar_bit-1:0] rsvd;
    } icache_op_bar_t;

    typedef struct packed {
        logic [26:0] rsvd_hi;
        logic [1:0]  code;     // bits 4:3
        logic [2:0]  rsvd_lo;
    } icache_op_cacop_t;

    // one operation word, read as barrier first and as cache-op otherwise
    typedef union packed {
        icache_op_bar_t   bar;
        icache_op_cacop_t cacop;
    } icache_op_u;

endpackage

`default_nettype wire

// ==== verilog/icache_store_if.sv ====
`default_nettype none

interface icache_store_if import icache_pkg::*; ();

    logic [way_count-1:0] data_we;
    logic [way_count-1:0] tagv_we;
    logic [way_count-1:0] inval;     // clear one valid bit at the held index
    logic                 ibar;      // clear every valid bit
    logic [way_count-1:0] touch;     // lru update
    logic [31:0]          refill_data;

    logic [way_count-1:0] hit;
    logic [31:0]          hit_data;
    logic                 victim;    // lru way of the held set

    modport ctrl (
        output data_we, tagv_we, inval, ibar, touch, refill_data,
        input  hit, hit_data, victim
    );

    modport store (
        input  data_we, tagv_we, inval, ibar, touch, refill_data,
        output hit, hit_data, victim
    );

endinterface

`default_nettype wire

// ==== verilog/icache_req_buf.sv ====
`default_nettype none

module icache_req_buf import icache_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rstn,
    input  wire logic         buf_we,
    input  wire logic [31:0]  in_addr,
    input  wire logic [31:0]  in_opcode,
    input  wire logic         in_opflag,
    input  wire logic         in_uncached,
    output icache_addr_t      held_addr,
    output icache_op_u        held_op,
    output logic              held_opflag,
    output logic              held_uncached
);

    // holds the accepted request for the whole lookup / refill / op,
    // so the arrays never see the live pipeline inputs
    always_ff @(posedge clk) begin
        if (!rstn) begin
            held_addr     <= '0;
            held_op       <= '0;
            held_opflag   <= 1'b0;
            held_uncached <= 1'b0;
        end else if (buf_we) begin
            held_addr     <= icache_addr_t'(in_addr);
            held_op       <= icache_op_u'(in_opcode);
            held_opflag   <= in_opflag;
            held_uncached <= in_uncached;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/icache_ctrl.sv ====
`default_nettype none

module icache_ctrl import icache_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rstn,
    input  wire logic          fetch_valid,
    output logic               fetch_ready,
    input  wire icache_addr_t  held_addr,
    input  wire icache_op_u    held_op,
    input  wire logic          held_opflag,
    input  wire logic          held_uncached,
    input  wire logic          fetch_opflag,
    output logic               buf_we,
    output logic               resp_valid,
    output logic [31:0]        resp_data,
    output logic               op_ack,
    output logic               mem_req,
    input  wire logic          mem_data_ok,
    input  wire logic [31:0]   mem_rdata,
    icache_store_if.ctrl       store
);

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_miss_wait,
        st_operation
    } state_t;

    state_t state;
    state_t next_state;

    logic rstn_q;
    logic ready_c;
    logic accept;
    logic miss;
    logic [1:0] code;

    always_ff @(posedge clk) begin
        rstn_q <= rstn;   // keeps ready low in the first cycle out of reset
    end

    assign fetch_ready = ready_c & rstn_q;
    assign accept      = fetch_valid & fetch_ready;
    assign buf_we      = accept;

    assign miss = ~|store.hit | held_uncached;
    assign code = held_op.cacop.code;

    assign store.refill_data = mem_rdata;

    ////////////////////////////////////////
    // state register and next state
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = st_idle;
        case (state)
            st_idle, st_operation: begin
                if (accept) next_state = fetch_opflag ? st_operation : st_lookup;
            end
            st_lookup: begin
                if (miss) begin
                    next_state = st_miss_wait;
                end else if (accept) begin
                    next_state = fetch_opflag ? st_operation : st_lookup;
                end
            end
            st_miss_wait: begin
                if (!mem_data_ok) begin
                    next_state = st_miss_wait;
                end else if (accept) begin
                    next_state = fetch_opflag ? st_operation : st_lookup;
                end
            end
            default: next_state = st_idle;
        endcase
    end

    ////////////////////////////////////////
    // outputs
    ////////////////////////////////////////

    always_comb begin
        ready_c       = 1'b0;
        resp_valid    = 1'b0;
        resp_data     = store.hit_data;
        op_ack        = 1'b0;
        mem_req       = 1'b0;
        store.data_we = '0;
        store.tagv_we = '0;
        store.inval   = '0;
        store.ibar    = 1'b0;
        store.touch   = '0;
        case (state)
            st_idle: ready_c = 1'b1;
            st_lookup: begin
                if (miss) begin
                    mem_req = 1'b1;
                    if (held_uncached) store.inval = store.hit;   // drop stale copy
                end else begin
                    ready_c     = 1'b1;
                    resp_valid  = 1'b1;
                    store.touch = store.hit;
                end
            end
            st_miss_wait: begin
                mem_req   = 1'b1;
                resp_data = mem_rdata;
                if (mem_data_ok) begin
                    ready_c    = 1'b1;
                    resp_valid = 1'b1;
                    if (!held_uncached) begin
                        // refill into the lru way
                        store.data_we[store.victim] = 1'b1;
                        store.tagv_we[store.victim] = 1'b1;
                        store.touch[store.victim]   = 1'b1;
                    end
                end
            end
            st_operation: begin
                ready_c = 1'b1;
                op_ack  = 1'b1;   // every op finishes in this one cycle
                if (held_opflag) begin
                    if (held_op.bar.ibar) begin
                        store.ibar = 1'b1;
                    end else if (code == cacop_hit_inv) begin
                        store.inval = store.hit;
                    end else if (code == cacop_index_inv || code == 2'd0) begin
                        store.inval[held_addr.offset[0]] = 1'b1;
                    end
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/icache_way_store.sv ====
`default_nettype none

module icache_way_store import icache_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rstn,
    input  wire icache_addr_t  addr,
    icache_store_if.store      store
);

    ////////////////////////////////////////
    // arrays
    ////////////////////////////////////////

    logic [tag_width-1:0]      tag_mem  [way_count][2**index_width];
    logic [31:0]               data_mem [way_count][2**index_width];
    logic [2**index_width-1:0] valid    [way_count];
    logic [2**index_width-1:0] lru;   // 1 means way 1 is next out

    logic [index_width-1:0] idx;

    assign idx = addr.index;

    // tag and data, no reset
    always_ff @(posedge clk) begin
        for (int w = 0; w < way_count; w++) begin
            if (store.tagv_we[w]) tag_mem[w][idx] <= addr.tag;
            if (store.data_we[w]) data_mem[w][idx] <= store.refill_data;
        end
    end

    // valid bits, wiped by reset and by the barrier
    always_ff @(posedge clk) begin
        if (!rstn || store.ibar) begin
            for (int w = 0; w < way_count; w++) begin
                valid[w] <= '0;
            end
        end else begin
            for (int w = 0; w < way_count; w++) begin
                if (store.tagv_we[w]) begin
                    valid[w][idx] <= 1'b1;
                end else if (store.inval[w]) begin
                    valid[w][idx] <= 1'b0;
                end
            end
        end
    end

    // touched way becomes most recent
    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru <= '0;
        end else if (store.touch[0]) begin
            lru[idx] <= 1'b1;
        end else if (store.touch[1]) begin
            lru[idx] <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < way_count; w++) begin
            store.hit[w] = valid[w][idx] && (tag_mem[w][idx] == addr.tag);
        end
    end

    assign store.hit_data = store.hit[1] ? data_mem[1][idx] : data_mem[0][idx];
    assign store.victim   = lru[idx];

endmodule

`default_nettype wire

// ==== verilog/icache_top.sv ====
`default_nettype none

module icache_top import icache_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rstn,

    // fetch side
    input  wire logic         fetch_valid,
    output logic              fetch_ready,
    input  wire logic [31:0]  fetch_addr,
    input  wire logic         fetch_opflag,
    input  wire logic [31:0]  fetch_opcode,
    input  wire logic         fetch_uncached,
    output logic              resp_valid,
    output logic [31:0]       resp_data,
    output logic              op_ack,

    // memory side, one word per refill
    output logic              mem_req,
    output logic [31:0]       mem_addr,
    input  wire logic         mem_data_ok,
    input  wire logic [31:0]  mem_rdata
);

    icache_addr_t held_addr;
    icache_op_u   held_op;
    logic         held_opflag;
    logic         held_uncached;
    logic         buf_we;

    icache_store_if store_bus ();

    assign mem_addr = held_addr;   // word address straight from the buffer

    icache_req_buf u_req_buf (
        .clk           (clk),
        .rstn          (rstn),
        .buf_we        (buf_we),
        .in_addr       (fetch_addr),
        .in_opcode     (fetch_opcode),
        .in_opflag     (fetch_opflag),
        .in_uncached   (fetch_uncached),
        .held_addr     (held_addr),
        .held_op       (held_op),
        .held_opflag   (held_opflag),
        .held_uncached (held_uncached)
    );

    icache_ctrl u_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .fetch_valid   (fetch_valid),
        .fetch_ready   (fetch_ready),
        .held_addr     (held_addr),
        .held_op       (held_op),
        .held_opflag   (held_opflag),
        .held_uncached (held_uncached),
        .fetch_opflag  (fetch_opflag),
        .buf_we        (buf_we),
        .resp_valid    (resp_valid),
        .resp_data     (resp_data),
        .op_ack        (op_ack),
        .mem_req       (mem_req),
        .mem_data_ok   (mem_data_ok),
        .mem_rdata     (mem_rdata),
        .store         (store_bus.ctrl)
    );

    icache_way_store u_way_store (
        .clk   (clk),
        .rstn  (rstn),
        .addr  (held_addr),
        .store (store_bus.store)
    );

endmodule

`default_nettype wire

// ==== bench/icache_checker.sv ====
`default_nettype none

module icache_checker (
    input wire logic clk,
    input wire logic rstn,
    input wire logic fetch_ready,
    input wire logic resp_valid,
    input wire logic op_ack,
    input wire logic mem_req,
    input wire logic mem_data_ok
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;

    // refill request holds until memory answers
    req_held: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_data_ok |=> mem_req)
    else begin
        $error("mem_req dropped before mem_data_ok");
        fail_count++;
    end

    no_double_resp: assert property (@(posedge clk) disable iff (!rstn)
        !(resp_valid && op_ack))
    else begin
        $error("resp_valid and op_ack high in the same cycle");
        fail_count++;
    end

    // ready is gated by the registered reset
    ready_after_reset: assert property (@(posedge clk) $rose(rstn) |-> !fetch_ready)
    else begin
        $error("fetch_ready high in the first cycle after reset");
        fail_count++;
    end

endmodule

bind icache_top icache_checker u_checker (
    .clk         (clk),
    .rstn        (rstn),
    .fetch_ready (fetch_ready),
    .resp_valid  (resp_valid),
    .op_ack      (op_ack),
    .mem_req     (mem_req),
    .mem_data_ok (mem_data_ok)
);

`default_nettype wire

// ==== bench/icache_monitor.sv ====
`default_nettype none

module icache_monitor (
    input  wire logic          clk,
    input  wire logic          rstn,
    input  wire logic          fetch_valid,
    input  wire logic          fetch_ready,
    input  wire logic [107:0]  fetch_pattern,   // pattern currently on the fetch port
    input  wire logic          resp_valid,
    input  wire logic [31:0]   resp_data,
    input  wire logic          op_ack,
    input  wire logic          mem_req,
    input  wire logic          mem_data_ok,
    output int                 done_count,
    output int                 err_count
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [107:0] pending[$];   // accepted, not yet answered
    logic [107:0] cur;
    int           mem_starts;
    int           wait_cycles;
    logic         mem_busy;

    task automatic check_response(input logic [107:0] p, input int starts, input int lat);
        int   errs_before;
        logic is_op;
        errs_before = err_count;
        is_op = (p[107:104] == 4'h1);
        if (is_op && !op_ack) begin
            $display("request %0d: operation answered with resp_valid, no op_ack", done_count);
            err_count++;
        end else if (!is_op && !resp_valid) begin
            $display("request %0d: fetch answered with op_ack, no resp_valid", done_count);
            err_count++;
        end else if (!is_op && resp_data !== p[35:4]) begin
            $display("Fail resp_data: expected %h, got %h (request %0d)",
                     p[35:4], resp_data, done_count);
            err_count++;
        end
        if (starts != p[3:0]) begin
            $display("Fail mem_req count: expected %h, got %h (request %0d)",
                     p[3:0], starts, done_count);
            err_count++;
        end
        if (p[3:0] == 4'h0 && lat != 1) begin
            $display("request %0d: answer took %0d cycles instead of one", done_count, lat);
            err_count++;
        end
        if (err_count == errs_before) begin
            $display("request %0d ok: addr %h", done_count, p[103:72]);
        end
        done_count++;
    endtask

    initial begin
        done_count = 0;
        err_count  = 0;
    end

    // sampled mid-cycle, values are what the next rising edge sees
    always @(negedge clk) begin
        if (!rstn) begin
            pending.delete();
            mem_starts  = 0;
            wait_cycles = 0;
            mem_busy    = 1'b0;
        end else begin
            if (mem_req && !mem_busy) begin
                mem_starts++;   // new memory transaction
                mem_busy = 1'b1;
            end
            if (mem_data_ok) mem_busy = 1'b0;
            wait_cycles++;
            if (resp_valid || op_ack) begin
                if (pending.size() == 0) begin
                    $display("response seen with no request outstanding");
                    err_count++;
                end else begin
                    cur = pending.pop_front();
                    check_response(cur, mem_starts, wait_cycles);
                end
                mem_starts = 0;
            end
            if (fetch_valid && fetch_ready) begin
                pending.push_back(fetch_pattern);
                wait_cycles = 0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/icache_tb.sv ====
`default_nettype none

module icache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_patterns = 64;

    logic         clk;
    logic         rstn;
    logic         fetch_valid;
    logic         fetch_ready;
    logic [31:0]  fetch_addr;
    logic         fetch_opflag;
    logic [31:0]  fetch_opcode;
    logic         fetch_uncached;
    logic         resp_valid;
    logic [31:0]  resp_data;
    logic         op_ack;
    logic         mem_req;
    logic [31:0]  mem_addr;
    logic         mem_data_ok;
    logic [31:0]  mem_rdata;

    logic [107:0] patterns [max_patterns];
    logic [107:0] pattern_now;
    int           n_patterns;
    int           timeout_limit;
    int           done_count;
    int           err_count;

    icache_top dut (.*);

    icache_monitor u_monitor (
        .clk           (clk),
        .rstn          (rstn),
        .fetch_valid   (fetch_valid),
        .fetch_ready   (fetch_ready),
        .fetch_pattern (pattern_now),
        .resp_valid    (resp_valid),
        .resp_data     (resp_data),
        .op_ack        (op_ack),
        .mem_req       (mem_req),
        .mem_data_ok   (mem_data_ok),
        .done_count    (done_count),
        .err_count     (err_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // memory model
    ////////////////////////////////////////

    initial begin : memory_model
        int unsigned delay;
        int unsigned discard;
        discard     = $urandom(406);
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        forever begin
            @(negedge clk);
            if (mem_req) begin
                delay = 1 + $urandom % 4;   // 1 to 4 cycles
                repeat (delay) @(posedge clk);
                #1;
                mem_rdata   = ~mem_addr;
                mem_data_ok = 1'b1;
                @(posedge clk);
                #1;
                mem_data_ok = 1'b0;
            end
        end
    end

    // holds the request until the DUT takes it
    task automatic send_request(input logic [107:0] p);
        fetch_valid    = 1'b1;
        fetch_opflag   = (p[107:104] == 4'h1);
        fetch_addr     = p[103:72];
        fetch_opcode   = p[71:40];
        fetch_uncached = p[36];
        pattern_now    = p;
        @(negedge clk);
        while (!fetch_ready) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin : stimulus
        rstn           = 1'b0;
        fetch_valid    = 1'b0;
        fetch_addr     = '0;
        fetch_opflag   = 1'b0;
        fetch_opcode   = '0;
        fetch_uncached = 1'b0;
        pattern_now    = '0;
        for (int i = 0; i < max_patterns; i++) patterns[i] = '1;   // kind f marks the end
        $readmemh("bench/icache_patterns.txt", patterns);
        n_patterns = 0;
        while (n_patterns < max_patterns && patterns[n_patterns][107:104] != 4'hf) begin
            n_patterns++;
        end
        timeout_limit = n_patterns * 8 + 50;
        repeat (5) @(posedge clk);
        #1 rstn = 1'b1;
        for (int i = 0; i < n_patterns; i++) begin
            send_request(patterns[i]);
        end
        fetch_valid = 1'b0;
        while (done_count < n_patterns) @(posedge clk);
        @(posedge clk);
        $display("%0d of %0d requests checked, %0d errors, %0d assertion failures",
                 done_count, n_patterns, err_count, dut.u_checker.fail_count);
        if (err_count == 0 && dut.u_checker.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        @(posedge clk);
        cycles++;
        while (cycles < timeout_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d of %0d requests answered",
                 cycles, done_count, n_patterns);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/icache_patterns.txt ====
// kind(0 fetch, 1 op) _ address _ operation word _ uncached _ expected data _ expected miss
// data returned by memory is the bitwise inverse of the address
0_00001004_00000000_0_ffffeffb_1
0_00001004_00000000_0_ffffeffb_0
0_00002008_00000000_0_ffffdff7_1
0_00003008_00000000_0_ffffcff7_1
0_00002008_00000000_0_ffffdff7_0
0_00004008_00000000_0_ffffbff7_1
0_00002008_00000000_0_ffffdff7_0
0_00003008_00000000_0_ffffcff7_1
0_0000500c_00000000_0_ffffaff3_1
0_0000500c_00000000_0_ffffaff3_0
0_0000500c_00000000_1_ffffaff3_1
0_0000500c_00000000_0_ffffaff3_1
0_00006010_00000000_0_ffff9fef_1
1_00006010_00000010_0_00000000_0
0_00006010_00000000_0_ffff9fef_1
0_00006010_00000000_0_ffff9fef_0
1_00006011_00000008_0_00000000_0
0_00006010_00000000_0_ffff9fef_1
1_00000000_80000000_0_00000000_0
0_00001004_00000000_0_ffffeffb_1
0_00002008_00000000_0_ffffdff7_1
0_0000500c_00000000_0_ffffaff3_1
0_00001004_00000000_0_ffffeffb_0

// ==== icache_top.f ====
verilog/icache_pkg.sv
verilog/icache_store_if.sv
verilog/icache_req_buf.sv
verilog/icache_ctrl.sv
verilog/icache_way_store.sv
verilog/icache_top.sv
bench/icache_checker.sv
bench/icache_monitor.sv
bench/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - files:
      - verilog/icache_pkg.sv
      - verilog/icache_store_if.sv
      - verilog/icache_req_buf.sv
      - verilog/icache_ctrl.sv
      - verilog/icache_way_store.sv
      - verilog/icache_top.sv
  - target: test
    files:
      - bench/icache_checker.sv
      - bench/icache_monitor.sv
      - bench/icache_tb.sv
